// ==== source/wb_bus_pkg.sv ====
//====================
// Wishbone signal widths shared by every bus port
// Byte select is one bit per data byte, so DATA_W must be a multiple of 8
// Module ADDR_W and DATA_W parameters must match these widths
//====================

package wb_bus_pkg;

	// Address and data widths of the bus
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;

	// Number of byte lanes in one data word
	localparam int WB_SEL_W = WB_DATA_W / 8;

	// Byte address as seen on adr
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;

	// One data word, write or read side
	typedef logic [WB_DATA_W-1:0] wb_data_t;

	// Byte enables, bit i covers data[8*i+7:8*i]
	typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage

// ==== source/wb_xbar_pkg.sv ====
//====================
// Crossbar topology: 3 masters, 4 slaves, one decode-error target
// The error target always sits right after the last slave
//====================

package wb_xbar_pkg;

	// Initiators on the master side
	localparam int N_MASTERS = 3;

	// Real slaves behind the crossbar
	localparam int N_SLAVES = 4;

	// Slaves plus the built-in error responder
	localparam int N_TARGETS = N_SLAVES + 1;

	// Index of the error responder among the targets
	localparam int ERR_TARGET = N_SLAVES;

	// Master index, 2 bits for 3 masters
	typedef logic [$clog2(N_MASTERS)-1:0] master_id_t;

	// Target index, 3 bits for 5 targets
	typedef logic [$clog2(N_TARGETS)-1:0] target_id_t;

	// One request or grant bit per master
	typedef logic [N_MASTERS-1:0] master_vec_t;

	// Per-master tracker
	// Idle until a strobe, then waiting on ack or err
	typedef enum logic [0:0] {
		TRK_IDLE = 1'b0,
		TRK_WAIT = 1'b1
	} trk_state_e;

endpackage

// ==== source/wb_addr_decoder.sv ====
//====================
// Window bounds are inclusive, lowest index wins on overlap
// Unmapped addresses decode to the error target
//====================
`timescale 1ns/100ps

module wb_addr_decoder
	import wb_bus_pkg::*;
	import wb_xbar_pkg::*;
#(
	parameter int       ADDR_W                  = WB_ADDR_W,
	parameter wb_addr_t SLAVE_BASE  [N_SLAVES]  = '{default: '0},
	parameter wb_addr_t SLAVE_LIMIT [N_SLAVES]  = '{default: '0}
) (
	input  wb_addr_t   adr_i,
	output target_id_t target_o
);

	// Address at the configured bus width
	logic [ADDR_W-1:0] adr;

	// Set once a window has claimed the address
	logic hit;

	assign adr = adr_i;

	always_comb begin
		// Nothing matched yet, default to the error responder
		hit      = 1'b0;
		target_o = target_id_t'(ERR_TARGET);
		// Scan from window 0 upward, first match is kept
		for (int s = 0; s < N_SLAVES; s++) begin
			if (!hit && adr >= SLAVE_BASE[s] && adr <= SLAVE_LIMIT[s]) begin
				hit      = 1'b1;
				target_o = target_id_t'(s);
			end
		end
	end

endmodule

// ==== source/wb_master_tracker.sv ====
//====================
// One tracker per master, classic single cycles only
// Master must hold cyc/stb/adr until ack or err ends the cycle
//====================
`timescale 1ns/100ps

module wb_master_tracker
	import wb_bus_pkg::*;
	import wb_xbar_pkg::*;
#(
	parameter int       ADDR_W                  = WB_ADDR_W,
	parameter wb_addr_t SLAVE_BASE  [N_SLAVES]  = '{default: '0},
	parameter wb_addr_t SLAVE_LIMIT [N_SLAVES]  = '{default: '0}
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       cyc_i,
	input  logic       stb_i,
	input  wb_addr_t   adr_i,
	input  logic       done_i,
	output target_id_t target_o,
	output logic       active_o
);

	trk_state_e state_q;

	// Target latched at the start of the cycle
	target_id_t target_q;

	// Decode of the live address
	target_id_t dec_target;

	wb_addr_decoder #(
		.ADDR_W      (ADDR_W),
		.SLAVE_BASE  (SLAVE_BASE),
		.SLAVE_LIMIT (SLAVE_LIMIT)
	) wb_addr_decoder_i (
		.adr_i    (adr_i),
		.target_o (dec_target)
	);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q  <= TRK_IDLE;
			target_q <= target_id_t'(ERR_TARGET);
		end else begin
			case (state_q)
				TRK_IDLE: begin
					// New request, lock in where it goes
					if (cyc_i && stb_i) begin
						state_q  <= TRK_WAIT;
						target_q <= dec_target;
					end
				end
				TRK_WAIT: begin
					// Ack or err from the routed target ends the cycle
					if (done_i) begin
						state_q <= TRK_IDLE;
					end
				end
				default: state_q <= TRK_IDLE;
			endcase
		end
	end

	// Request toward the arbiter of target_o while waiting
	assign active_o = (state_q == TRK_WAIT);
	assign target_o = target_q;

endmodule

// ==== source/wb_rr_arbiter.sv ====
//====================
// Round-robin over N_MASTERS, one grant at a time
// Grant is held while the owner requests, then idles one cycle
//====================
`timescale 1ns/100ps

module wb_rr_arbiter
	import wb_xbar_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  master_vec_t req_i,
	output logic        gnt_valid_o,
	output master_id_t  gnt_id_o
);

	// Grant state
	logic        gnt_valid_q;
	master_id_t  gnt_id_q;

	// One-hot copy of the most recent grant, kept after release
	master_vec_t last_gnt_q;

	// Bits strictly above the last grant
	master_vec_t above_mask;

	// Requests that come after the last winner in round-robin order
	master_vec_t masked_req;

	// One-hot winner for the next grant
	master_vec_t pick;

	// Isolate the lowest set bit
	function automatic master_vec_t lowest_bit(master_vec_t v);
		return v & (~v + master_vec_t'(1));
	endfunction

	// One-hot to index
	function automatic master_id_t onehot2id(master_vec_t v);
		master_id_t id;
		id = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (v[i]) begin
				id = master_id_t'(i);
			end
		end
		return id;
	endfunction

	// Thermometer mask, set for every position past the last grant
	always_comb begin
		above_mask = '0;
		for (int i = 1; i < N_MASTERS; i++) begin
			above_mask[i] = above_mask[i-1] | last_gnt_q[i-1];
		end
	end

	assign masked_req = req_i & above_mask;

	// Next in turn, else wrap to the lowest requester
	assign pick = (|masked_req) ? lowest_bit(masked_req) : lowest_bit(req_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_valid_q <= 1'b0;
			gnt_id_q    <= '0;
			last_gnt_q  <= '0;
		end else if (!gnt_valid_q) begin
			// Free, hand out to whoever is next
			if (|pick) begin
				gnt_valid_q <= 1'b1;
				gnt_id_q    <= onehot2id(pick);
				last_gnt_q  <= pick;
			end
		end else if (!req_i[gnt_id_q]) begin
			// Owner finished, release for one cycle
			gnt_valid_q <= 1'b0;
		end
	end

	assign gnt_valid_o = gnt_valid_q;
	assign gnt_id_o    = gnt_id_q;

endmodule

// ==== source/wb_xbar_mux.sv ====
//====================
// Purely combinational request and response routing
// Idle targets and ungranted masters see all-zero signals
//====================
`timescale 1ns/100ps

module wb_xbar_mux
	import wb_bus_pkg::*;
	import wb_xbar_pkg::*;
#(
	parameter int ADDR_W = WB_ADDR_W,
	parameter int DATA_W = WB_DATA_W
) (
	// Master side
	input  logic        m_cyc_i     [N_MASTERS],
	input  logic        m_stb_i     [N_MASTERS],
	input  logic        m_we_i      [N_MASTERS],
	input  wb_addr_t    m_adr_i     [N_MASTERS],
	input  wb_data_t    m_wdat_i    [N_MASTERS],
	input  wb_sel_t     m_sel_i     [N_MASTERS],
	input  target_id_t  m_target_i  [N_MASTERS],
	input  logic        m_active_i  [N_MASTERS],
	output wb_data_t    m_rdat_o    [N_MASTERS],
	output logic        m_ack_o     [N_MASTERS],
	output logic        m_err_o     [N_MASTERS],
	// Target side
	input  logic        t_gnt_valid_i [N_TARGETS],
	input  master_id_t  t_gnt_id_i    [N_TARGETS],
	output logic        t_cyc_o       [N_TARGETS],
	output logic        t_stb_o       [N_TARGETS],
	output logic        t_we_o        [N_TARGETS],
	output wb_addr_t    t_adr_o       [N_TARGETS],
	output wb_data_t    t_wdat_o      [N_TARGETS],
	output wb_sel_t     t_sel_o       [N_TARGETS],
	input  wb_data_t    t_rdat_i      [N_TARGETS],
	input  logic        t_ack_i       [N_TARGETS],
	input  logic        t_err_i       [N_TARGETS]
);

	// Request path, one slice per target
	for (genvar t = 0; t < N_TARGETS; t++) begin : g_tgt
		master_id_t        id;
		logic              fwd;
		logic [ADDR_W-1:0] adr_sel;
		logic [DATA_W-1:0] wdat_sel;
		logic [DATA_W/8-1:0] sel_sel;

		assign id = t_gnt_id_i[t];

		// Owner must still be mid-cycle on this very target
		// Drops stb right after ack, before the grant is released
		assign fwd = t_gnt_valid_i[t] && m_active_i[id] &&
			(m_target_i[id] == target_id_t'(t));

		assign adr_sel  = m_adr_i[id];
		assign wdat_sel = m_wdat_i[id];
		assign sel_sel  = m_sel_i[id];

		assign t_cyc_o[t]  = fwd & m_cyc_i[id];
		assign t_stb_o[t]  = fwd & m_stb_i[id];
		assign t_we_o[t]   = fwd & m_we_i[id];
		assign t_adr_o[t]  = fwd ? adr_sel : '0;
		assign t_wdat_o[t] = fwd ? wdat_sel : '0;
		assign t_sel_o[t]  = fwd ? sel_sel : '0;
	end

	// Response path, one slice per master
	for (genvar m = 0; m < N_MASTERS; m++) begin : g_mst
		target_id_t        tgt;
		logic              own;
		logic [DATA_W-1:0] rdat_sel;

		assign tgt = m_target_i[m];

		// This master holds the grant of the target it is waiting on
		assign own = m_active_i[m] && t_gnt_valid_i[tgt] &&
			(t_gnt_id_i[tgt] == master_id_t'(m));

		assign rdat_sel = t_rdat_i[tgt];

		// Ack comes straight back in the slave's cycle
		assign m_ack_o[m]  = own & t_ack_i[tgt];
		assign m_err_o[m]  = own & t_err_i[tgt];
		assign m_rdat_o[m] = own ? rdat_sel : '0;
	end

endmodule

// ==== source/wb_decode_err_slave.sv ====
//====================
// Error target for unmapped addresses
// Answers every strobe with a one-cycle err, never acks, no data
//====================
`timescale 1ns/100ps

module wb_decode_err_slave (
	input  logic clk,
	input  logic rstn,
	input  logic cyc_i,
	input  logic stb_i,
	output logic err_o
);

	// Registered err pulse
	logic err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			// Raise one cycle after the strobe
			// Clear on the next edge even if stb is still up
			err_q <= cyc_i && stb_i && !err_q;
		end
	end

	// The mux gates stb as soon as the master has seen err
	// so no second pulse follows for the same cycle
	assign err_o = err_q;

endmodule

// ==== source/wb_xbar_top.sv ====
//====================
// 3x4 Wishbone classic crossbar, single transfers only
// Unmapped addresses end with err from an internal target
// ADDR_W and DATA_W must match the bus package widths
//====================
`timescale 1ns/100ps

module wb_xbar_top
	import wb_bus_pkg::*;
	import wb_xbar_pkg::*;
#(
	parameter int       ADDR_W                 = WB_ADDR_W,
	parameter int       DATA_W                 = WB_DATA_W,
	parameter wb_addr_t SLAVE_BASE  [N_SLAVES] = '{32'h0000_0000, 32'h0000_1000,
		32'h0000_2000, 32'h0000_3000},
	parameter wb_addr_t SLAVE_LIMIT [N_SLAVES] = '{32'h0000_0fff, 32'h0000_1fff,
		32'h0000_2fff, 32'h0000_3fff}
) (
	input  logic     clk,
	input  logic     rstn,
	// Masters
	input  logic     m_cyc_i  [N_MASTERS],
	input  logic     m_stb_i  [N_MASTERS],
	input  logic     m_we_i   [N_MASTERS],
	input  wb_addr_t m_adr_i  [N_MASTERS],
	input  wb_data_t m_wdat_i [N_MASTERS],
	input  wb_sel_t  m_sel_i  [N_MASTERS],
	output wb_data_t m_rdat_o [N_MASTERS],
	output logic     m_ack_o  [N_MASTERS],
	output logic     m_err_o  [N_MASTERS],
	// Slaves
	output logic     s_cyc_o  [N_SLAVES],
	output logic     s_stb_o  [N_SLAVES],
	output logic     s_we_o   [N_SLAVES],
	output wb_addr_t s_adr_o  [N_SLAVES],
	output wb_data_t s_wdat_o [N_SLAVES],
	output wb_sel_t  s_sel_o  [N_SLAVES],
	input  wb_data_t s_rdat_i [N_SLAVES],
	input  logic     s_ack_i  [N_SLAVES],
	input  logic     s_err_i  [N_SLAVES]
);

	// Tracker outputs
	target_id_t  trk_target [N_MASTERS];
	logic        trk_active [N_MASTERS];
	logic        trk_done   [N_MASTERS];

	// Arbiter side, slaves plus error target
	master_vec_t t_req       [N_TARGETS];
	logic        t_gnt_valid [N_TARGETS];
	master_id_t  t_gnt_id    [N_TARGETS];

	// Routed target buses
	logic        t_cyc  [N_TARGETS];
	logic        t_stb  [N_TARGETS];
	logic        t_we   [N_TARGETS];
	wb_addr_t    t_adr  [N_TARGETS];
	wb_data_t    t_wdat [N_TARGETS];
	wb_sel_t     t_sel  [N_TARGETS];
	wb_data_t    t_rdat [N_TARGETS];
	logic        t_ack  [N_TARGETS];
	logic        t_err  [N_TARGETS];

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_trk
		// Either response closes the master's cycle
		assign trk_done[m] = m_ack_o[m] | m_err_o[m];

		wb_master_tracker #(
			.ADDR_W      (ADDR_W),
			.SLAVE_BASE  (SLAVE_BASE),
			.SLAVE_LIMIT (SLAVE_LIMIT)
		) wb_master_tracker_i (
			.clk      (clk),
			.rstn     (rstn),
			.cyc_i    (m_cyc_i[m]),
			.stb_i    (m_stb_i[m]),
			.adr_i    (m_adr_i[m]),
			.done_i   (trk_done[m]),
			.target_o (trk_target[m]),
			.active_o (trk_active[m])
		);
	end

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_arb
		// Request bit m is set while master m waits on target t
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_req
			assign t_req[t][m] = trk_active[m] && (trk_target[m] == target_id_t'(t));
		end

		wb_rr_arbiter wb_rr_arbiter_i (
			.clk         (clk),
			.rstn        (rstn),
			.req_i       (t_req[t]),
			.gnt_valid_o (t_gnt_valid[t]),
			.gnt_id_o    (t_gnt_id[t])
		);
	end

	// Slave ports map to the first N_SLAVES targets
	for (genvar s = 0; s < N_SLAVES; s++) begin : g_slv
		assign s_cyc_o[s]  = t_cyc[s];
		assign s_stb_o[s]  = t_stb[s];
		assign s_we_o[s]   = t_we[s];
		assign s_adr_o[s]  = t_adr[s];
		assign s_wdat_o[s] = t_wdat[s];
		assign s_sel_o[s]  = t_sel[s];
		assign t_rdat[s]   = s_rdat_i[s];
		assign t_ack[s]    = s_ack_i[s];
		assign t_err[s]    = s_err_i[s];
	end

	// Error target returns no data and no ack
	assign t_rdat[ERR_TARGET] = '0;
	assign t_ack[ERR_TARGET]  = 1'b0;

	wb_decode_err_slave wb_decode_err_slave_i (
		.clk   (clk),
		.rstn  (rstn),
		.cyc_i (t_cyc[ERR_TARGET]),
		.stb_i (t_stb[ERR_TARGET]),
		.err_o (t_err[ERR_TARGET])
	);

	wb_xbar_mux #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) wb_xbar_mux_i (
		.m_cyc_i       (m_cyc_i),
		.m_stb_i       (m_stb_i),
		.m_we_i        (m_we_i),
		.m_adr_i       (m_adr_i),
		.m_wdat_i      (m_wdat_i),
		.m_sel_i       (m_sel_i),
		.m_target_i    (trk_target),
		.m_active_i    (trk_active),
		.m_rdat_o      (m_rdat_o),
		.m_ack_o       (m_ack_o),
		.m_err_o       (m_err_o),
		.t_gnt_valid_i (t_gnt_valid),
		.t_gnt_id_i    (t_gnt_id),
		.t_cyc_o       (t_cyc),
		.t_stb_o       (t_stb),
		.t_we_o        (t_we),
		.t_adr_o       (t_adr),
		.t_wdat_o      (t_wdat),
		.t_sel_o       (t_sel),
		.t_rdat_i      (t_rdat),
		.t_ack_i       (t_ack),
		.t_err_i       (t_err)
	);

endmodule

// ==== testbench/tb_clkgen.sv ====
//====================
// 4 ns clock, active-low reset held for 8 cycles
// Reset is released on a falling edge
//====================
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk_o,
	output logic rstn_o
);

	// 2 ns half period
	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	initial begin
		rstn_o = 1'b0;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rstn_o = 1'b1;
	end

endmodule

// ==== testbench/tb_wb_xbar.sv ====
//====================
// Random traffic from 3 masters into 4 memory slaves, plus unmapped accesses
// Master m only touches words whose address bits [3:2] equal m
// A contention phase sends all masters to one slave to check round-robin order
//====================
`timescale 1ns/100ps

module tb_wb_xbar
	import wb_bus_pkg::*;
	import wb_xbar_pkg::*;
();

	localparam int CLK_PERIOD_NS = 4;
	localparam int N_RAND        = 40;
	localparam int N_CONT        = 6;
	localparam int CONT_SLAVE    = 2;
	localparam int MEM_WORDS     = 16;
	localparam int WATCHDOG_NS   =
		(N_MASTERS * (N_RAND + N_CONT) * 200 + 40) * CLK_PERIOD_NS;

	// Address map handed to the DUT
	localparam wb_addr_t WIN_BASE [N_SLAVES] = '{32'h0000_0000, 32'h0000_1000,
		32'h0000_2000, 32'h0000_3000};
	localparam wb_addr_t WIN_LIMIT [N_SLAVES] = '{32'h0000_0fff, 32'h0000_1fff,
		32'h0000_2fff, 32'h0000_3fff};

	logic clk;
	logic rstn;

	// Master side
	logic     m_cyc    [N_MASTERS];
	logic     m_stb    [N_MASTERS];
	logic     m_we     [N_MASTERS];
	wb_addr_t m_adr    [N_MASTERS];
	wb_data_t m_wdat   [N_MASTERS];
	wb_sel_t  m_sel    [N_MASTERS];
	wb_data_t m_rdat_o [N_MASTERS];
	logic     m_ack_o  [N_MASTERS];
	logic     m_err_o  [N_MASTERS];

	// Slave side
	logic     s_cyc_o  [N_SLAVES];
	logic     s_stb_o  [N_SLAVES];
	logic     s_we_o   [N_SLAVES];
	wb_addr_t s_adr_o  [N_SLAVES];
	wb_data_t s_wdat_o [N_SLAVES];
	wb_sel_t  s_sel_o  [N_SLAVES];
	wb_data_t s_rdat   [N_SLAVES];
	logic     s_ack    [N_SLAVES];
	logic     s_err    [N_SLAVES];

	// Slave memories and the reference model
	wb_data_t slave_mem [N_SLAVES][MEM_WORDS];
	wb_data_t model_mem [N_SLAVES][MEM_WORDS];
	logic     model_wr  [N_SLAVES][MEM_WORDS];

	// Reads that returned data written earlier, per slave
	int raw_hits [N_SLAVES];

	logic [31:0] lfsr_q = 32'hea02_127f;

	int data_errs = 0;
	int resp_errs = 0;
	int other_errs = 0;
	int err_ops = 0;

	// Phase control
	logic go = 1'b0;
	logic contend_on = 1'b0;
	logic [N_MASTERS-1:0] rand_done = '0;
	logic [N_MASTERS-1:0] all_done = '0;

	// Fairness monitor state
	int served;
	int last1 = -1;
	int last2 = -1;
	int cont_served = 0;

	tb_clkgen tb_clkgen_i (
		.clk_o  (clk),
		.rstn_o (rstn)
	);

	wb_xbar_top #(
		.ADDR_W      (WB_ADDR_W),
		.DATA_W      (WB_DATA_W),
		.SLAVE_BASE  (WIN_BASE),
		.SLAVE_LIMIT (WIN_LIMIT)
	) wb_xbar_top_i (
		.clk      (clk),
		.rstn     (rstn),
		.m_cyc_i  (m_cyc),
		.m_stb_i  (m_stb),
		.m_we_i   (m_we),
		.m_adr_i  (m_adr),
		.m_wdat_i (m_wdat),
		.m_sel_i  (m_sel),
		.m_rdat_o (m_rdat_o),
		.m_ack_o  (m_ack_o),
		.m_err_o  (m_err_o),
		.s_cyc_o  (s_cyc_o),
		.s_stb_o  (s_stb_o),
		.s_we_o   (s_we_o),
		.s_adr_o  (s_adr_o),
		.s_wdat_o (s_wdat_o),
		.s_sel_o  (s_sel_o),
		.s_rdat_i (s_rdat),
		.s_ack_i  (s_ack),
		.s_err_i  (s_err)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit, newest bit lands in bit 0
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[31]};
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	// Initial content of unwritten words
	function automatic wb_data_t fill_word(input wb_addr_t a);
		return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
	endfunction

	// First window holding the address, -1 when unmapped
	function automatic int window_of(input wb_addr_t adr);
		for (int s = 0; s < N_SLAVES; s++) begin
			if (adr >= WIN_BASE[s] && adr <= WIN_LIMIT[s]) begin
				return s;
			end
		end
		return -1;
	endfunction

	task automatic fill_memories();
		for (int s = 0; s < N_SLAVES; s++) begin
			raw_hits[s] = 0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				slave_mem[s][i] = fill_word(WIN_BASE[s] + wb_addr_t'(i * 4));
				model_mem[s][i] = fill_word(WIN_BASE[s] + wb_addr_t'(i * 4));
				model_wr[s][i]  = 1'b0;
			end
		end
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp) begin
			data_errs++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			resp_errs++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Nothing may move on the bus before the first request
	task automatic check_quiet_bus();
		for (int s = 0; s < N_SLAVES; s++) begin
			check_err($sformatf("reset s%0d cyc", s), 1'b0, s_cyc_o[s]);
			check_err($sformatf("reset s%0d stb", s), 1'b0, s_stb_o[s]);
		end
		for (int m = 0; m < N_MASTERS; m++) begin
			check_err($sformatf("reset m%0d ack", m), 1'b0, m_ack_o[m]);
			check_err($sformatf("reset m%0d err", m), 1'b0, m_err_o[m]);
		end
	endtask

	task automatic release_bus(input int m);
		@(negedge clk);
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		m_we[m]  = 1'b0;
	endtask

	// One classic cycle, then compare against the model
	task automatic run_op(input int m, input logic we, input wb_addr_t adr,
		input wb_data_t wdat);
		string name;
		int s;
		int idx;
		logic ack;
		logic err;
		wb_data_t rdat;
		name = $sformatf("m%0d %s %h", m, we ? "write" : "read", adr);
		s = window_of(adr);
		@(negedge clk);
		m_cyc[m]  = 1'b1;
		m_stb[m]  = 1'b1;
		m_we[m]   = we;
		m_adr[m]  = adr;
		m_wdat[m] = wdat;
		m_sel[m]  = '1;
		// Hold until the crossbar answers
		do begin
			@(posedge clk);
		end while (!(m_ack_o[m] || m_err_o[m]));
		ack  = m_ack_o[m];
		err  = m_err_o[m];
		rdat = m_rdat_o[m];
		if (s < 0) begin
			check_err({name, " err"}, 1'b1, err);
			check_err({name, " ack"}, 1'b0, ack);
			err_ops++;
		end else begin
			check_err({name, " err"}, 1'b0, err);
			check_err({name, " ack"}, 1'b1, ack);
			idx = adr[5:2];
			if (we) begin
				model_mem[s][idx] = wdat;
				model_wr[s][idx]  = 1'b1;
			end else begin
				check_data(name, model_mem[s][idx], rdat);
				if (model_wr[s][idx]) begin
					raw_hits[s]++;
				end
			end
		end
	endtask

	task automatic run_master(input int m);
		logic [31:0] r;
		wb_addr_t adr;
		wb_data_t wdat;
		logic we;
		wait (go);
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(1, r);
			we = r[0];
			take_bits(32, r);
			wdat = r;
			take_bits(3, r);
			if (r[2:0] == 3'd0) begin
				// Above every window
				take_bits(12, r);
				adr = {r[11:0], 20'h0} | 32'h0010_0000 | (wb_addr_t'(m) << 2);
			end else begin
				// Slave in r[3:2], word in r[1:0]
				take_bits(4, r);
				adr = WIN_BASE[r[3:2]] + wb_addr_t'({r[1:0], 4'h0}) + (wb_addr_t'(m) << 2);
			end
			run_op(m, we, adr, wdat);
			take_bits(1, r);
			if (r[0]) begin
				release_bus(m);
			end
		end
		release_bus(m);
		rand_done[m] = 1'b1;
		// Back-to-back write then read pairs on one slave
		wait (contend_on);
		for (int i = 0; i < N_CONT; i++) begin
			take_bits(32, r);
			adr = WIN_BASE[CONT_SLAVE] + (wb_addr_t'(i / 2) << 4) + (wb_addr_t'(m) << 2);
			run_op(m, (i % 2) == 0, adr, r);
		end
		release_bus(m);
		all_done[m] = 1'b1;
	endtask

	// Word memory, acks 0 to 3 cycles after seeing the strobe
	// Writes only touch the byte lanes selected on sel
	task automatic serve_slave(input int s);
		logic [31:0] d;
		int idx;
		forever begin
			@(negedge clk);
			s_ack[s]  = 1'b0;
			s_rdat[s] = '0;
			if (rstn && s_cyc_o[s] && s_stb_o[s]) begin
				if (s_adr_o[s] < WIN_BASE[s] || s_adr_o[s] > WIN_LIMIT[s]) begin
					other_errs++;
					$display("Slave %0d got a strobe at %h, outside its window", s, s_adr_o[s]);
				end
				take_bits(2, d);
				repeat (d[1:0]) @(negedge clk);
				idx = s_adr_o[s][5:2];
				if (s_we_o[s]) begin
					for (int b = 0; b < WB_SEL_W; b++) begin
						if (s_sel_o[s][b]) begin
							slave_mem[s][idx][8*b +: 8] = s_wdat_o[s][8*b +: 8];
						end
					end
				end else begin
					s_rdat[s] = slave_mem[s][idx];
				end
				s_ack[s] = 1'b1;
			end
		end
	endtask

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
		initial run_master(m);
	end

	for (genvar s = 0; s < N_SLAVES; s++) begin : g_slave
		initial serve_slave(s);
	end

	// Owner of each completed access is in address bits [3:2]
	always @(posedge clk) begin
		if (contend_on && s_stb_o[CONT_SLAVE] && s_ack[CONT_SLAVE]) begin
			served = int'(s_adr_o[CONT_SLAVE][3:2]);
			if (served == last1 || served == last2) begin
				other_errs++;
				$display("Master %0d got slave %0d again while another master waited",
					served, CONT_SLAVE);
			end
			last2 = last1;
			last1 = served;
			cont_served++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with transactions still open", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		for (int m = 0; m < N_MASTERS; m++) begin
			m_cyc[m]  = 1'b0;
			m_stb[m]  = 1'b0;
			m_we[m]   = 1'b0;
			m_adr[m]  = '0;
			m_wdat[m] = '0;
			m_sel[m]  = '0;
		end
		for (int s = 0; s < N_SLAVES; s++) begin
			s_rdat[s] = '0;
			s_ack[s]  = 1'b0;
			s_err[s]  = 1'b0;
		end
		fill_memories();
		wait (rstn === 1'b1);
		repeat (4) begin
			@(posedge clk);
			check_quiet_bus();
		end
		go = 1'b1;
		wait (&rand_done);
		contend_on = 1'b1;
		wait (&all_done);
		contend_on = 1'b0;
		repeat (4) @(posedge clk);
		// Coverage of the behaviors that random traffic must reach
		for (int s = 0; s < N_SLAVES; s++) begin
			if (raw_hits[s] == 0) begin
				other_errs++;
				$display("No read returned written data in slave %0d window", s);
			end
		end
		if (err_ops == 0) begin
			other_errs++;
			$display("No access to an unmapped address was made");
		end
		if (cont_served != N_MASTERS * N_CONT) begin
			other_errs++;
			$display("Contended slave served %0d accesses, not %0d",
				cont_served, N_MASTERS * N_CONT);
		end
		$display("Errors: data %0d, response %0d, other %0d",
			data_errs, resp_errs, other_errs);
		if (data_errs + resp_errs + other_errs == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
source/wb_bus_pkg.sv
source/wb_xbar_pkg.sv
source/wb_addr_decoder.sv
source/wb_master_tracker.sv
source/wb_rr_arbiter.sv
source/wb_xbar_mux.sv
source/wb_decode_err_slave.sv
source/wb_xbar_top.sv
testbench/tb_clkgen.sv
testbench/tb_wb_xbar.sv
